//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // T-cycles per M-cycle and longest instruction in M-cycles
    localparam int T_PER_M = 4;
    localparam int M_MAX   = 3;

    localparam logic [1:0] T_RD = 2'd2;              // Memory strobe in T3
    localparam logic [1:0] T_WB = 2'(T_PER_M - 1);   // Writeback in T4

    // Register encoding as in the opcode fields
    typedef enum logic [2:0] {
        REG_B  = 3'd0,
        REG_C  = 3'd1,
        REG_D  = 3'd2,
        REG_E  = 3'd3,
        REG_H  = 3'd4,
        REG_L  = 3'd5,
        MEM_HL = 3'd6,
        REG_A  = 3'd7
    } reg_sel_e;

    typedef enum logic [1:0] {WB_SBUS, WB_ALU, WB_MEM} wb_src_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_XOR, ALU_OR, ALU_CP
    } alu_op_e;

    typedef enum logic [1:0] {IDC_NONE, IDC_INC, IDC_DEC} incdec_e;

    typedef enum logic {PAIR_PC, PAIR_HL} addr_pair_e;

    typedef enum logic [2:0] {
        CLS_NOP, CLS_LD_RR, CLS_LD_RN, CLS_LD_RHL,
        CLS_LD_RRNN, CLS_INC_R, CLS_DEC_R, CLS_ALU_AR
    } instr_class_e;

    typedef struct packed {
        logic       rd_en;
        reg_sel_e   rd_addr;
        logic       drive_addr;    // Address bus carries a read address
        addr_pair_e addr_pair;
        logic       alu_begin;
        alu_op_e    alu_op;
        incdec_e    incdec;
        logic       wr_en;
        reg_sel_e   wr_addr;
        wb_src_e    wb_src;
        logic       flag_wr;
        logic       inc_pc;
    } ctrl_t;

    // Same bit order as the upper nibble of F
    typedef struct packed {
        logic z;
        logic n;
        logic h;
        logic c;
    } flags_t;

endpackage

`default_nettype wire

//--- source/cycle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [1:0] m_count,   // M-cycles of the current instruction
    output logic      [1:0] m_cycle,
    output logic      [1:0] t_cycle,
    output logic            m1t1
);
    import cpu_pkg::*;

    logic [3:0] cycle;   // {M, T}
    logic       last_m;

    assign m_cycle = cycle[3:2];
    assign t_cycle = cycle[1:0];
    assign m1t1    = (cycle == 4'd0);

    assign last_m = (m_cycle == 2'(m_count - 2'd1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cycle <= 4'd0;
        end else if (last_m && t_cycle == T_WB) begin
            cycle <= 4'd0;   // Next instruction starts at M1T1
        end else begin
            cycle <= cycle + 4'd1;
        end
    end

    // Decoded length must always cover the running M-cycle
    a_m_in_range: assert property (@(posedge clk) disable iff (!rst)
        m_cycle < m_count);

endmodule

`default_nettype wire

//--- source/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic [7:0] mem_data,
    input  wire logic [1:0] m_cycle,
    input  wire logic [1:0] t_cycle,
    input  wire logic       m1t1,
    output logic      [1:0] m_count,
    output cpu_pkg::ctrl_t  ctrl,
    output logic            mem_rd
);
    import cpu_pkg::*;

    logic [7:0]   ir;   // Instruction register
    instr_class_e cls;
    reg_sel_e     dst;
    reg_sel_e     src;
    logic         t_wb;

    assign dst  = reg_sel_e'(ir[5:3]);
    assign src  = reg_sel_e'(ir[2:0]);
    assign t_wb = (t_cycle == T_WB);

    // Opcode captured at the end of M1 T3
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ir <= 8'h00;
        end else if (mem_rd && m_cycle == 2'd0) begin
            ir <= mem_data;
        end
    end

    always_comb begin
        cls = CLS_NOP;   // Anything unsupported runs as a NOP
        case (ir[7:6])
            2'b00: begin
                if (ir[2:0] == 3'b110 && dst != MEM_HL) cls = CLS_LD_RN;
                else if (ir[3:0] == 4'b0001 && ir[5:4] != 2'b11) cls = CLS_LD_RRNN;
                else if (ir[2:0] == 3'b100 && dst != MEM_HL) cls = CLS_INC_R;
                else if (ir[2:0] == 3'b101 && dst != MEM_HL) cls = CLS_DEC_R;
            end
            2'b01: begin
                if (dst != MEM_HL && src != MEM_HL) cls = CLS_LD_RR;
                else if (src == MEM_HL && dst != MEM_HL) cls = CLS_LD_RHL;
            end
            2'b10: if (src != MEM_HL) cls = CLS_ALU_AR;
            default: cls = CLS_NOP;
        endcase
    end

    always_comb begin
        case (cls)
            CLS_LD_RN, CLS_LD_RHL: m_count = 2'd2;
            CLS_LD_RRNN:           m_count = 2'(M_MAX);
            default:               m_count = 2'd1;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl.drive_addr = (m_cycle == 2'd0);   // Opcode fetch through PC
        case (cls)
            CLS_LD_RR: begin
                ctrl.rd_en   = 1'b1;
                ctrl.rd_addr = src;
                ctrl.wr_en   = 1'b1;
                ctrl.wr_addr = dst;
                ctrl.wb_src  = WB_SBUS;
            end
            CLS_INC_R, CLS_DEC_R: begin
                ctrl.rd_en     = 1'b1;
                ctrl.rd_addr   = dst;   // Register is its own operand
                ctrl.alu_begin = 1'b1;
                ctrl.incdec    = (cls == CLS_INC_R) ? IDC_INC : IDC_DEC;
                ctrl.wr_en     = 1'b1;
                ctrl.wr_addr   = dst;
                ctrl.wb_src    = WB_ALU;
                ctrl.flag_wr   = 1'b1;
            end
            CLS_ALU_AR: begin
                ctrl.rd_en     = 1'b1;
                ctrl.rd_addr   = src;
                ctrl.alu_begin = 1'b1;
                ctrl.alu_op    = alu_op_e'(ir[5:3]);
                ctrl.wr_en     = (ir[5:3] != ALU_CP);   // CP only compares
                ctrl.wr_addr   = REG_A;
                ctrl.wb_src    = WB_ALU;
                ctrl.flag_wr   = 1'b1;
            end
            CLS_LD_RN, CLS_LD_RHL: begin
                if (m_cycle == 2'd1) begin
                    ctrl.drive_addr = 1'b1;
                    ctrl.addr_pair  = (cls == CLS_LD_RHL) ? PAIR_HL : PAIR_PC;
                    ctrl.wr_en      = 1'b1;
                    ctrl.wr_addr    = dst;
                    ctrl.wb_src     = WB_MEM;
                end
            end
            CLS_LD_RRNN: begin
                // Low byte in M2, high byte in M3
                if (m_cycle != 2'd0) begin
                    ctrl.drive_addr = 1'b1;
                    ctrl.wr_en      = 1'b1;
                    ctrl.wr_addr    = reg_sel_e'({ir[5:4], m_cycle == 2'd1});
                    ctrl.wb_src     = WB_MEM;
                end
            end
            default: ;
        endcase

        // Enables fire only in T4 once the opcode is latched
        ctrl.rd_en     = ctrl.rd_en & t_wb;
        ctrl.alu_begin = ctrl.alu_begin & t_wb;
        ctrl.wr_en     = ctrl.wr_en & t_wb;
        ctrl.flag_wr   = ctrl.flag_wr & t_wb;
        ctrl.inc_pc    = ctrl.drive_addr && ctrl.addr_pair == PAIR_PC && t_wb;
    end

    assign mem_rd = ctrl.drive_addr && (t_cycle == T_RD);

    a_strobe_slots: assert property (@(posedge clk) disable iff (!rst)
        (!mem_rd || t_cycle == T_RD) && (!ctrl.wr_en || t_wb));

    // The next opcode fetch follows the decoded last T4 at once
    a_length_honored: assert property (@(posedge clk) disable iff (!rst)
        t_wb && m_cycle == 2'(m_count - 2'd1) |=> m1t1);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic        clk,
    input  wire logic        rst,
    input  cpu_pkg::ctrl_t   ctrl,
    input  wire logic        mem_rd,
    input  wire logic [7:0]  mem_data,
    input  wire logic        wb_en,
    input  cpu_pkg::reg_sel_e wb_addr,
    input  wire logic [7:0]  wb_data,
    output logic      [7:0]  rd_data,    // Operand bus
    output logic      [7:0]  acc,
    output logic      [7:0]  mem_latch,
    output logic      [15:0] mem_addr
);
    import cpu_pkg::*;

    logic [7:0]  regs [8];   // Slot 6 is (HL) and never written
    logic [15:0] pc;
    logic [15:0] hl;

    assign hl      = {regs[REG_H], regs[REG_L]};
    assign acc     = regs[REG_A];
    assign rd_data = ctrl.rd_en ? regs[ctrl.rd_addr] : 8'h00;

    // HL only for LD r,(HL), PC otherwise
    assign mem_addr = (ctrl.drive_addr && ctrl.addr_pair == PAIR_HL) ? hl : pc;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
        end else if (wb_en && wb_addr != MEM_HL) begin
            regs[wb_addr] <= wb_data;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= 16'h0000;
        end else if (ctrl.inc_pc) begin
            pc <= pc + 16'd1;   // End of T4 after a PC read
        end
    end

    // Data byte held from T3 for writeback in T4
    always_ff @(posedge clk) begin
        if (mem_rd) begin
            mem_latch <= mem_data;
        end
    end

endmodule

`default_nettype wire

//--- source/alu_exec.sv
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  cpu_pkg::ctrl_t  ctrl,
    input  wire logic [7:0] acc,
    input  wire logic [7:0] rd_data,
    input  cpu_pkg::flags_t flags_in,
    output logic      [7:0] result,
    output cpu_pkg::flags_t flags_out
);
    import cpu_pkg::*;

    logic [8:0] sum;    // Bit 8 is carry or borrow
    logic [4:0] half;   // Bit 4 is nibble carry or borrow
    logic       cin;

    always_comb begin
        result    = rd_data;
        flags_out = flags_in;
        cin       = 1'b0;
        sum       = 9'd0;
        half      = 5'd0;
        if (ctrl.alu_begin && ctrl.incdec == IDC_INC) begin
            result      = rd_data + 8'd1;
            flags_out.n = 1'b0;
            flags_out.h = (rd_data[3:0] == 4'hf);
            flags_out.z = (result == 8'h00);   // C untouched
        end else if (ctrl.alu_begin && ctrl.incdec == IDC_DEC) begin
            result      = rd_data - 8'd1;
            flags_out.n = 1'b1;
            flags_out.h = (rd_data[3:0] == 4'h0);
            flags_out.z = (result == 8'h00);
        end else if (ctrl.alu_begin) begin
            case (ctrl.alu_op)
                ALU_ADD, ALU_ADC: begin
                    cin       = (ctrl.alu_op == ALU_ADC) & flags_in.c;
                    sum       = {1'b0, acc} + {1'b0, rd_data} + 9'(cin);
                    half      = {1'b0, acc[3:0]} + {1'b0, rd_data[3:0]} + 5'(cin);
                    result    = sum[7:0];
                    flags_out = '{z: (sum[7:0] == 8'h00), n: 1'b0, h: half[4], c: sum[8]};
                end
                ALU_SUB, ALU_SBC, ALU_CP: begin
                    cin       = (ctrl.alu_op == ALU_SBC) & flags_in.c;
                    sum       = {1'b0, acc} - {1'b0, rd_data} - 9'(cin);
                    half      = {1'b0, acc[3:0]} - {1'b0, rd_data[3:0]} - 5'(cin);
                    result    = (ctrl.alu_op == ALU_CP) ? acc : sum[7:0];
                    flags_out = '{z: (sum[7:0] == 8'h00), n: 1'b1, h: half[4], c: sum[8]};
                end
                ALU_AND: begin
                    result    = acc & rd_data;
                    flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b1, c: 1'b0};
                end
                ALU_XOR: begin
                    result    = acc ^ rd_data;
                    flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
                end
                default: begin   // OR
                    result    = acc | rd_data;
                    flags_out = '{z: (result == 8'h00), n: 1'b0, h: 1'b0, c: 1'b0};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic         clk,
    input  wire logic         rst,
    input  cpu_pkg::ctrl_t    ctrl,
    input  wire logic [7:0]   rd_data,
    input  wire logic [7:0]   mem_latch,
    input  wire logic [7:0]   result,
    input  cpu_pkg::flags_t   flags_out,
    output logic              wb_en,
    output cpu_pkg::reg_sel_e wb_addr,
    output logic      [7:0]   wb_data,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    assign wb_en   = ctrl.wr_en;
    assign wb_addr = ctrl.wr_addr;

    always_comb begin
        case (ctrl.wb_src)
            WB_SBUS: wb_data = rd_data;     // Register to register
            WB_MEM:  wb_data = mem_latch;
            default: wb_data = result;
        endcase
    end

    // F register, written at T4 together with the result
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flags <= '0;
        end else if (ctrl.flag_wr) begin
            flags <= flags_out;
        end
    end

    // Decode never targets the (HL) slot with a register write
    a_no_hl_write: assert property (@(posedge clk) disable iff (!rst)
        wb_en |-> wb_addr != MEM_HL);

endmodule

`default_nettype wire

//--- source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core (
    input  wire logic         clk,
    input  wire logic         rst,
    output logic      [15:0]  mem_addr,
    output logic              mem_rd,
    input  wire logic [7:0]   mem_data,
    output logic              wb_en,
    output cpu_pkg::reg_sel_e wb_addr,
    output logic      [7:0]   wb_data,
    output cpu_pkg::flags_t   flags
);
    import cpu_pkg::*;

    logic [1:0] m_cycle;
    logic [1:0] t_cycle;
    logic       m1t1;
    logic [1:0] m_count;
    ctrl_t      ctrl;
    logic [7:0] rd_data;
    logic [7:0] acc;
    logic [7:0] mem_latch;
    logic [7:0] result;
    flags_t     flags_out;

    cycle_timer cycle_timer_i (
        .clk(clk), .rst(rst), .m_count(m_count),
        .m_cycle(m_cycle), .t_cycle(t_cycle), .m1t1(m1t1)
    );

    instr_decode instr_decode_i (
        .clk(clk), .rst(rst), .mem_data(mem_data), .m_cycle(m_cycle),
        .t_cycle(t_cycle), .m1t1(m1t1), .m_count(m_count), .ctrl(ctrl), .mem_rd(mem_rd)
    );

    reg_file reg_file_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .mem_rd(mem_rd), .mem_data(mem_data),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .rd_data(rd_data),
        .acc(acc), .mem_latch(mem_latch), .mem_addr(mem_addr)
    );

    alu_exec alu_exec_i (
        .ctrl(ctrl), .acc(acc), .rd_data(rd_data), .flags_in(flags),
        .result(result), .flags_out(flags_out)
    );

    result_stage result_stage_i (
        .clk(clk), .rst(rst), .ctrl(ctrl), .rd_data(rd_data), .mem_latch(mem_latch),
        .result(result), .flags_out(flags_out), .wb_en(wb_en), .wb_addr(wb_addr),
        .wb_data(wb_data), .flags(flags)
    );

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic [15:0] mem_addr,
    input wire logic        mem_rd,
    input wire logic        wb_en,
    input wire logic [2:0]  wb_addr,
    input wire logic [7:0]  wb_data,
    input wire logic [3:0]  flags
);
    import cpu_pkg::*;

    logic [7:0]  r [8];        // Model registers, slot 6 unused
    logic [15:0] pc;
    flags_t      f;
    logic [10:0] wq [$];       // Expected writes {addr, data}
    logic [15:0] aq [$];       // Expected operand read addresses
    int          exp_len;
    int          since_fetch;
    int          idle;
    logic        started;
    int          err_count = 0;
    int          fetch_count = 0;

    function automatic logic [7:0] mem_at(input logic [15:0] a);
        return tb_top.mem[a[7:0]];
    endfunction

    task automatic write_reg(input logic [2:0] a, input logic [7:0] v);
        wq.push_back({a, v});
        r[a] = v;
    endtask

    task automatic incdec(input logic [2:0] d, input logic inc);
        logic [7:0] v;
        v = inc ? r[d] + 8'd1 : r[d] - 8'd1;
        f.n = !inc;
        f.h = inc ? (r[d][3:0] == 4'hf) : (r[d][3:0] == 4'h0);
        f.z = (v == 8'h00);   // Carry kept
        write_reg(d, v);
    endtask

    task automatic alu(input logic [2:0] op, input logic [7:0] b);
        int a;
        int cin;
        int res;
        a   = r[7];
        cin = ((op == 3'd1 || op == 3'd3) && f.c) ? 1 : 0;
        res = 0;
        case (op)
            3'd0, 3'd1: begin
                res = a + b + cin;
                f   = '{z: (res[7:0] == 0), n: 1'b0,
                        h: ((a % 16) + (b % 16) + cin) > 15, c: res > 255};
            end
            3'd2, 3'd3, 3'd7: begin
                res = a - b - cin;
                f   = '{z: (res[7:0] == 0), n: 1'b1,
                        h: (a % 16) < (b % 16) + cin, c: a < b + cin};
            end
            3'd4: begin
                res = a & b;
                f   = '{z: (res == 0), n: 1'b0, h: 1'b1, c: 1'b0};
            end
            3'd5: begin
                res = a ^ b;
                f   = '{z: (res == 0), n: 1'b0, h: 1'b0, c: 1'b0};
            end
            default: begin
                res = a | b;
                f   = '{z: (res == 0), n: 1'b0, h: 1'b0, c: 1'b0};
            end
        endcase
        if (op != 3'd7) write_reg(3'd7, res[7:0]);   // CP keeps A
    endtask

    // One whole instruction at the model PC
    task automatic execute();
        logic [7:0]  op;
        logic [2:0]  d;
        logic [2:0]  s;
        logic [15:0] hl;
        logic [15:0] npc;
        op      = mem_at(pc);
        d       = op[5:3];
        s       = op[2:0];
        hl      = {r[4], r[5]};
        npc     = pc + 16'd1;
        exp_len = 1;
        case (op[7:6])
            2'b00: begin
                if (s == 3'd6 && d != 3'd6) begin
                    aq.push_back(pc + 16'd1);
                    write_reg(d, mem_at(pc + 16'd1));
                    exp_len = 2;
                    npc     = pc + 16'd2;
                end else if (op[3:0] == 4'h1 && op[5:4] != 2'b11) begin
                    aq.push_back(pc + 16'd1);
                    aq.push_back(pc + 16'd2);
                    write_reg({op[5:4], 1'b1}, mem_at(pc + 16'd1));   // Low byte first
                    write_reg({op[5:4], 1'b0}, mem_at(pc + 16'd2));
                    exp_len = 3;
                    npc     = pc + 16'd3;
                end else if (s == 3'd4 && d != 3'd6) begin
                    incdec(d, 1'b1);
                end else if (s == 3'd5 && d != 3'd6) begin
                    incdec(d, 1'b0);
                end
            end
            2'b01: begin
                if (d != 3'd6 && s != 3'd6) begin
                    write_reg(d, r[s]);
                end else if (s == 3'd6 && d != 3'd6) begin
                    aq.push_back(hl);   // PC stays put for this read
                    write_reg(d, mem_at(hl));
                    exp_len = 2;
                end
            end
            2'b10: if (s != 3'd6) alu(d, r[s]);
            default: ;
        endcase
        pc = npc;
    endtask

    task automatic check_fetch();
        if (started) begin
            if (since_fetch != exp_len * T_PER_M) begin
                $display("fetch came %0d cycles after the last one, expected %0d",
                         since_fetch, exp_len * T_PER_M);
                err_count++;
            end
            if (wq.size() != 0) begin
                $display("register write missing before fetch at %h", pc);
                err_count++;
            end
            if (flags !== f) begin
                $display("error flags: got %h expected %h", flags, f);
                err_count++;
            end
        end
        wq.delete();
        if (mem_addr !== pc) begin
            $display("error mem_addr: got %h expected %h", mem_addr, pc);
            err_count++;
        end
        started     = 1'b1;
        since_fetch = 0;
        fetch_count++;
        execute();
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 8; i++) r[i] = 8'h00;
            pc          = 16'h0000;
            f           = '0;
            started     = 1'b0;
            fetch_count = 0;
            idle        = 0;
            since_fetch = 0;
            wq.delete();
            aq.delete();
            if (mem_rd) begin
                $display("mem_rd was high during reset");
                err_count++;
            end
        end else begin
            since_fetch++;
            idle++;
            if (wb_en) begin
                if (wq.size() == 0) begin
                    $display("register write to %h when none was expected", wb_addr);
                    err_count++;
                end else if ({wb_addr, wb_data} !== wq[0]) begin
                    $display("error wb_addr/wb_data: got %h/%h expected %h/%h",
                             wb_addr, wb_data, wq[0][10:8], wq[0][7:0]);
                    err_count++;
                    void'(wq.pop_front());
                end else begin
                    void'(wq.pop_front());
                end
            end
            if (mem_rd) begin
                idle = 0;
                if (aq.size() > 0) begin
                    if (mem_addr !== aq[0]) begin
                        $display("error mem_addr: got %h expected %h", mem_addr, aq[0]);
                        err_count++;
                    end
                    void'(aq.pop_front());
                end else begin
                    check_fetch();
                end
            end
            if (idle > T_PER_M * M_MAX) begin   // Watchdog on the read strobe
                $display("no memory read seen for %0d cycles", idle);
                err_count++;
                idle = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
    import cpu_pkg::*;

    logic        clk;
    logic        rst;
    logic [15:0] mem_addr;
    logic        mem_rd;
    logic [7:0]  mem_data;
    logic        wb_en;
    reg_sel_e    wb_addr;
    logic [7:0]  wb_data;
    flags_t      flags;
    logic [7:0]  mem [256];
    logic [31:0] lfsr = 32'h5bb2_b57e;
    int          passed = 0;
    int          failed = 0;

    assign mem_data = mem[mem_addr[7:0]];   // Combinational read

    cpu_core cpu_core_i (
        .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_rd(mem_rd), .mem_data(mem_data),
        .wb_en(wb_en), .wb_addr(wb_addr), .wb_data(wb_data), .flags(flags)
    );

    tb_checker tb_checker_i (
        .clk(clk), .rst(rst), .mem_addr(mem_addr), .mem_rd(mem_rd), .wb_en(wb_en),
        .wb_addr(wb_addr), .wb_data(wb_data), .flags(flags)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [7:0] v);
        v = 8'h00;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic pick_reg(output logic [2:0] sel);
        logic [7:0] v;
        rand_bits(3, v);
        sel = (v[2:0] == 3'd6) ? 3'd7 : v[2:0];   // Skip the (HL) slot
    endtask

    task automatic put_byte(inout int pos, input logic [7:0] b);
        mem[pos % 256] = b;
        pos++;
    endtask

    // Kinds 0 NOP, 1 LD r,n, 2 LD r,r', 3 LD rr,nn, 4 LD HL,nn,
    // 5 LD r,(HL), 6 ALU A,r, 7 INC, 8 DEC, 9 any byte
    task automatic emit_instr(input int kind, inout int pos);
        logic [2:0] d;
        logic [2:0] s;
        logic [7:0] v;
        pick_reg(d);
        pick_reg(s);
        rand_bits(8, v);
        case (kind)
            1: put_byte(pos, {2'b00, d, 3'b110});
            2: put_byte(pos, {2'b01, d, s});
            3: put_byte(pos, {2'b00, (v[1:0] == 2'b11) ? 2'b10 : v[1:0], 4'h1});
            4: put_byte(pos, 8'h21);
            5: put_byte(pos, {2'b01, d, 3'b110});
            6: put_byte(pos, {2'b10, v[2:0], s});
            7: put_byte(pos, {2'b00, d, 3'b100});
            8: put_byte(pos, {2'b00, d, 3'b101});
            9: put_byte(pos, v);
            default: put_byte(pos, 8'h00);
        endcase
        if (kind == 1) begin
            rand_bits(8, v);
            put_byte(pos, v);
        end else if (kind == 3 || kind == 4) begin
            rand_bits(8, v);
            put_byte(pos, v);
            rand_bits(8, v);
            put_byte(pos, v);
        end
    endtask

    task automatic load_program(input int num);
        int         pos;
        int         kind;
        logic [7:0] v;
        pos = 0;
        while (pos < 256) begin
            rand_bits(3, v);
            case (num)
                1: kind = 0;
                2: kind = (v[1:0] == 2'd3) ? 1 : v[1:0] + 1;
                3: kind = v[0] ? 5 : 4;
                4: kind = (v[1:0] == 2'd0) ? 1 : 6;
                5: kind = (v[1:0] == 2'd0) ? 1 : v[1:0] + 5;
                default: kind = (v[2:0] < 3'd3) ? v[2:0] + 1 : v[2:0] + 2;
            endcase
            emit_instr(kind, pos);
        end
    endtask

    task automatic run_test(input int num, input string name, input int count);
        int start_err;
        int waited;
        int errs;
        @(posedge clk);
        rst <= 1'b0;
        start_err = tb_checker_i.err_count;
        @(posedge clk);
        load_program(num);   // Core is held in reset while memory changes
        @(posedge clk);
        rst <= 1'b1;
        waited = 0;
        while (tb_checker_i.fetch_count < count + 1 && waited < count * 16 + 50) begin
            @(posedge clk);
            waited++;
        end
        errs = tb_checker_i.err_count - start_err;
        if (tb_checker_i.fetch_count < count + 1) begin
            $display("test %0d %s: timed out after %0d instructions", num, name,
                     tb_checker_i.fetch_count);
            failed++;
        end else if (errs != 0) begin
            $display("test %0d %s: %0d errors", num, name, errs);
            failed++;
        end else begin
            $display("test %0d %s: ok", num, name);
            passed++;
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i);
        end
        run_test(1, "reset and fetch", 20);
        run_test(2, "loads", 60);
        run_test(3, "memory read via HL", 60);
        run_test(4, "accumulator ALU", 80);
        run_test(5, "INC and DEC", 80);
        run_test(6, "mixed random program", 300);
        $display("tests passed %0d failed %0d", passed, failed);
        if (failed == 0 && tb_checker_i.err_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
source/cpu_pkg.sv
source/cycle_timer.sv
source/instr_decode.sv
source/reg_file.sv
source/alu_exec.sv
source/result_stage.sv
source/cpu_core.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
.PHONY: all run clean

all: obj_dir/Vtb_top

obj_dir/Vtb_top: list.f source/*.sv sim/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f list.f

run: obj_dir/Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; echo "$$out" | grep -qx 'TEST PASSED'

clean:
	rm -rf obj_dir
